/* hw/wcmp_cfg.svh */
// Width and beat-count macros for the stall-window monitor
`ifndef WCMP_CFG_SVH
`define WCMP_CFG_SVH

// Stall counter width
// Also sets the window arithmetic width, since it wraps at 2**width
`define WCMP_TIMER_W 8

// Data width of both stream ports
`define WCMP_DATA_W 8

// Beats in one result packet
// Beat 0 carries the count and the last beat carries the flag
`define WCMP_RESULT_BEATS 2

`endif

/* hw/wcmp_types_pkg.sv */
// Datapath types: timer and threshold vectors, window struct, control state enum
`include "wcmp_cfg.svh"

package wcmp_types_pkg;

    // Stall count, wraps modulo 2**WCMP_TIMER_W
    typedef logic [`WCMP_TIMER_W-1:0] timer_t;

    // Threshold shares the timer width
    // This keeps the modular window test in a single width
    typedef logic [`WCMP_TIMER_W-1:0] thresh_t;

    // Captured window bounds
    // high below low means the window wraps through zero
    typedef struct packed {
        thresh_t low;
        thresh_t high;
    } window_t;

    // Control FSM states
    //   ST_ACCEPT  taking threshold beats
    //   ST_COUNT   offering beat 0, counting stall cycles
    //   ST_FLAG    offering beat 1 with the window flag
    typedef enum logic [1:0] {
        ST_ACCEPT = 2'd0,
        ST_COUNT  = 2'd1,
        ST_FLAG   = 2'd2
    } ctrl_state_e;

endpackage

/* hw/wcmp_stream_pkg.sv */
// Stream types: AXI-Stream beat struct and result-beat select
`include "wcmp_cfg.svh"

package wcmp_stream_pkg;

    // One AXI-Stream beat
    // tvalid and tready stay separate since they run in opposite directions
    typedef struct packed {
        logic [`WCMP_DATA_W-1:0] data;
        logic                    last;
    } axis_beat_t;

    // Index of the result beat on the output port
    // Sized from the beat count, so 1 bit for a two-beat packet
    typedef logic [$clog2(`WCMP_RESULT_BEATS)-1:0] beat_sel_t;

    // Beat 0 carries the count
    // Any later index is the flag beat
    // With two beats the select is just "second beat"

endpackage

/* hw/wcmp_threshold_capture.sv */
// Threshold capture: latches low/high thresholds from input beats into a window
`timescale 1ns/1ps

module wcmp_threshold_capture (
    input  logic                        clk,
    input  logic                        rst_n,
    // Input handshake from control
    input  logic                        in_fire,
    input  wcmp_stream_pkg::axis_beat_t s_axis_beat,
    // Held window, valid until overwritten
    output wcmp_types_pkg::window_t     window
);

    import wcmp_types_pkg::*;
    import wcmp_stream_pkg::*;

    window_t   window_q;
    thresh_t   beat_thresh;
    axis_beat_t beat;

    // Local copy of the beat for field access
    assign beat = s_axis_beat;

    // Threshold taken from the beat data
    // Data and threshold widths match in the cfg header
    assign beat_thresh = thresh_t'(beat.data);

    // Non-last beats overwrite low, so the last non-last beat wins
    // The last beat always supplies high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window_q <= '0;
        end else if (in_fire) begin
            if (beat.last) begin
                window_q.high <= beat_thresh;
            end else begin
                window_q.low <= beat_thresh;
            end
        end
    end

    // One-beat packets keep the previous low
    assign window = window_q;

endmodule

/* hw/wcmp_stall_timer.sv */
// Stall timer: clearable wrap-around counter and modular window test
`timescale 1ns/1ps

module wcmp_stall_timer (
    input  logic                    clk,
    input  logic                    rst_n,
    // Clear at end of threshold packet
    input  logic                    cnt_clr,
    // Count one stalled cycle of beat 0
    input  logic                    count_en,
    input  wcmp_types_pkg::window_t window,
    output wcmp_types_pkg::timer_t  count,
    // Combinational, follows count
    output logic                    in_window
);

    import wcmp_types_pkg::*;

    timer_t count_q;
    // Offsets from low, both modulo 2**WCMP_TIMER_W
    timer_t count_off;
    timer_t span;

    // Clear wins over enable
    // Natural wrap of the vector gives the modulo count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (cnt_clr) begin
            count_q <= '0;
        end else if (count_en) begin
            count_q <= count_q + timer_t'(1);
        end
    end

    assign count = count_q;

    // Single range check for (count - low) mod N <= (high - low) mod N
    // Handles a window that wraps through zero
    assign count_off = count_q - window.low;
    assign span      = window.high - window.low;
    assign in_window = (count_off <= span);

    // Clear only in ST_ACCEPT, enable only in ST_COUNT
    a_clr_en_excl : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(cnt_clr && count_en)
    ) else $error("stall timer clear and enable high together");

endmodule

/* hw/wcmp_result_serializer.sv */
// Result serializer: holds count and window flag, muxes the two output beats
`timescale 1ns/1ps
`include "wcmp_cfg.svh"

module wcmp_result_serializer (
    input  logic                        clk,
    input  logic                        rst_n,
    // Beat 0 handshake
    input  logic                        result_load,
    input  wcmp_stream_pkg::beat_sel_t  beat_sel,
    input  wcmp_types_pkg::timer_t      count,
    input  logic                        in_window,
    output wcmp_stream_pkg::axis_beat_t m_axis_beat
);

    import wcmp_types_pkg::*;
    import wcmp_stream_pkg::*;

    // Held result, equal to what beat 0 sent
    timer_t     cnt_q;
    logic       flag_q;
    axis_beat_t beat;
    logic       last_beat;

    // Capture on the beat 0 handshake edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q  <= '0;
            flag_q <= 1'b0;
        end else if (result_load) begin
            cnt_q  <= count;
            flag_q <= in_window;
        end
    end

    // Final beat index of the result packet
    assign last_beat = (beat_sel == beat_sel_t'(`WCMP_RESULT_BEATS - 1));

    // Beat 0 shows the live count, no register stage
    // Flag beat only reads held state, so it stays put under back-pressure
    always_comb begin
        if (last_beat) begin
            beat.data = {{(`WCMP_DATA_W-1){1'b0}}, flag_q};
            beat.last = 1'b1;
        end else begin
            beat.data = `WCMP_DATA_W'(count);
            beat.last = 1'b0;
        end
    end

    assign m_axis_beat = beat;

    // Live count stays at the value beat 0 sent while the flag beat waits
    a_load_match : assert property (
        @(posedge clk) disable iff (!rst_n)
        last_beat |-> (cnt_q == count)
    ) else $error("count moved after beat 0 left");

endmodule

/* hw/wcmp_ctrl.sv */
// Control FSM: threshold acceptance, result output, both ready/valid sides
`timescale 1ns/1ps
`include "wcmp_cfg.svh"

module wcmp_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    // Input stream handshake
    input  logic                       s_axis_tvalid,
    input  logic                       s_axis_last,
    output logic                       s_axis_tready,
    // Output stream handshake
    output logic                       m_axis_tvalid,
    input  logic                       m_axis_tready,
    // Datapath controls
    output logic                       in_fire,
    output logic                       pkt_done,
    output logic                       cnt_clr,
    output logic                       count_en,
    output logic                       result_load,
    output wcmp_stream_pkg::beat_sel_t beat_sel
);

    import wcmp_types_pkg::*;
    import wcmp_stream_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        out_fire;

    // Input open only while accepting thresholds
    assign s_axis_tready = (state_q == ST_ACCEPT);
    assign in_fire       = s_axis_tvalid && s_axis_tready;
    assign pkt_done      = in_fire && s_axis_last;

    // Valid is purely state based, never looks at tready
    assign m_axis_tvalid = (state_q == ST_COUNT) || (state_q == ST_FLAG);
    assign out_fire      = m_axis_tvalid && m_axis_tready;

    // Fresh count for each packet
    assign cnt_clr = pkt_done;

    // Stalled cycles of beat 0 only
    assign count_en = (state_q == ST_COUNT) && !m_axis_tready;

    // Beat 0 leaves on this edge
    assign result_load = out_fire && (state_q == ST_COUNT);

    // Flag beat is the last beat of the packet
    assign beat_sel = (state_q == ST_FLAG) ? beat_sel_t'(`WCMP_RESULT_BEATS - 1)
                                           : beat_sel_t'(0);

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_ACCEPT: begin
                // Last threshold beat ends the packet
                if (pkt_done) begin
                    state_d = ST_COUNT;
                end
            end
            ST_COUNT: begin
                if (out_fire) begin
                    state_d = ST_FLAG;
                end
            end
            ST_FLAG: begin
                // Beat 1 taken, reopen the input
                if (out_fire) begin
                    state_d = ST_ACCEPT;
                end
            end
            default: begin
                state_d = ST_ACCEPT;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_ACCEPT;
        end else begin
            state_q <= state_d;
        end
    end

    // Output valid held until taken
    a_valid_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        (m_axis_tvalid && !m_axis_tready) |=> m_axis_tvalid
    ) else $error("output valid dropped before handshake");

endmodule

/* hw/wcmp_top.sv */
// Top level: control FSM and datapath wired to the two AXI-Stream ports
`timescale 1ns/1ps

module wcmp_top (
    input  logic                        clk,
    input  logic                        rst_n,
    // Threshold packets in
    input  logic                        s_axis_tvalid,
    output logic                        s_axis_tready,
    input  wcmp_stream_pkg::axis_beat_t s_axis_beat,
    // Result packets out
    output logic                        m_axis_tvalid,
    input  logic                        m_axis_tready,
    output wcmp_stream_pkg::axis_beat_t m_axis_beat
);

    import wcmp_types_pkg::*;
    import wcmp_stream_pkg::*;

    // Control to datapath
    logic      in_fire;
    logic      cnt_clr;
    logic      count_en;
    logic      result_load;
    beat_sel_t beat_sel;

    // Datapath internals
    window_t   window;
    timer_t    count;
    logic      in_window;

    // Sequencing and both handshakes
    wcmp_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_last   (s_axis_beat.last),
        .s_axis_tready (s_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .in_fire       (in_fire),
        .pkt_done      (),
        .cnt_clr       (cnt_clr),
        .count_en      (count_en),
        .result_load   (result_load),
        .beat_sel      (beat_sel)
    );

    wcmp_threshold_capture u_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_fire     (in_fire),
        .s_axis_beat (s_axis_beat),
        .window      (window)
    );

    wcmp_stall_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .cnt_clr   (cnt_clr),
        .count_en  (count_en),
        .window    (window),
        .count     (count),
        .in_window (in_window)
    );

    // Output beat formation
    wcmp_result_serializer u_serializer (
        .clk         (clk),
        .rst_n       (rst_n),
        .result_load (result_load),
        .beat_sel    (beat_sel),
        .count       (count),
        .in_window   (in_window),
        .m_axis_beat (m_axis_beat)
    );

endmodule

/* dv/tb_wcmp_top.sv */
// Testbench for wcmp_top: clock, reset, LFSR stimulus, reference model, assertion checks
`timescale 1ns/1ps

module tb_wcmp_top;

    import wcmp_types_pkg::*;
    import wcmp_stream_pkg::*;

    localparam int WAIT_LIMIT = 2000;

    logic        clk;
    logic        rst_n;
    logic        s_axis_tvalid;
    logic        s_axis_tready;
    axis_beat_t  s_axis_beat;
    logic        m_axis_tvalid;
    logic        m_axis_tready;
    axis_beat_t  m_axis_beat;

    // Reference model state
    logic        ref_busy;
    logic        ref_phase;
    logic [7:0]  ref_low;
    logic [7:0]  ref_high;
    int          ref_stall;
    logic        ref_flag;
    // Stimulus reach
    logic [31:0] lfsr;
    int          flag_stalls;
    int          max_stall;

    wcmp_top u_wcmp_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .s_axis_beat   (s_axis_beat),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_beat   (m_axis_beat)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic stop_run();
        $display("Test failed");
        $fatal(1);
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        int          k;
        val = '0;
        for (k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // Walk upward from low, wrapping past 255, until high
    function automatic logic window_holds(input logic [7:0] cnt, input logic [7:0] low,
                                          input logic [7:0] high);
        logic [7:0] pos;
        int         k;
        pos = low;
        for (k = 0; k < 256; k++) begin
            if (pos == cnt) begin
                return 1'b1;
            end
            if (pos == high) begin
                return 1'b0;
            end
            pos = pos + 8'd1;
        end
        return 1'b0;
    endfunction

    // Model follows the port handshakes it expects, not the DUT's
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_busy  <= 1'b0;
            ref_phase <= 1'b0;
            ref_low   <= 8'd0;
            ref_high  <= 8'd0;
            ref_stall <= 0;
            ref_flag  <= 1'b0;
        end else if (!ref_busy) begin
            if (s_axis_tvalid && s_axis_beat.last) begin
                ref_high  <= s_axis_beat.data;
                ref_busy  <= 1'b1;
                ref_phase <= 1'b0;
                ref_stall <= 0;
            end else if (s_axis_tvalid) begin
                ref_low <= s_axis_beat.data;
            end
        end else if (!ref_phase) begin
            // Count beat taken, flag fixed from the final count
            if (m_axis_tready) begin
                ref_phase <= 1'b1;
                ref_flag  <= window_holds(ref_stall[7:0], ref_low, ref_high);
            end else begin
                ref_stall <= ref_stall + 1;
            end
        end else if (m_axis_tready) begin
            ref_busy <= 1'b0;
        end
    end

    // Back-pressure on the flag beat and the longest stall seen
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag_stalls <= 0;
            max_stall   <= 0;
        end else begin
            if (u_wcmp_top.u_ctrl.state_q == ST_FLAG && !m_axis_tready) begin
                flag_stalls <= flag_stalls + 1;
            end
            if (ref_stall > max_stall) begin
                max_stall <= ref_stall;
            end
        end
    end

    // Input open exactly when no result is pending
    a_ready : assert property (@(posedge clk) disable iff (!rst_n)
        s_axis_tready == !ref_busy)
    else begin
        $display("CHECK FAILED s_axis_tready expected %h got %h",
                 !$sampled(ref_busy), $sampled(s_axis_tready));
        stop_run();
    end

    a_valid : assert property (@(posedge clk) disable iff (!rst_n)
        m_axis_tvalid == ref_busy)
    else begin
        $display("CHECK FAILED m_axis_tvalid expected %h got %h",
                 $sampled(ref_busy), $sampled(m_axis_tvalid));
        stop_run();
    end

    // Live stall count, last low
    a_count_beat : assert property (@(posedge clk) disable iff (!rst_n)
        (ref_busy && !ref_phase) |-> m_axis_beat == {ref_stall[7:0], 1'b0})
    else begin
        $display("CHECK FAILED m_axis_beat expected %h got %h",
                 {$sampled(ref_stall[7:0]), 1'b0}, $sampled(m_axis_beat));
        stop_run();
    end

    // Flag in bit 0, last high, held while stalled
    a_flag_beat : assert property (@(posedge clk) disable iff (!rst_n)
        (ref_busy && ref_phase) |-> m_axis_beat == {7'd0, ref_flag, 1'b1})
    else begin
        $display("CHECK FAILED m_axis_beat expected %h got %h",
                 {7'd0, $sampled(ref_flag), 1'b1}, $sampled(m_axis_beat));
        stop_run();
    end

    task automatic wait_out_valid(input string what);
        int n;
        n = 0;
        while (!m_axis_tvalid) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("Timed out waiting for output valid on the %s", what);
                stop_run();
            end
        end
    endtask

    // Holds the beat until the DUT takes it
    task automatic send_beat(input logic [7:0] data, input logic last);
        int n;
        n = 0;
        s_axis_tvalid    = 1'b1;
        s_axis_beat.data = data;
        s_axis_beat.last = last;
        while (!s_axis_tready) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("Timed out waiting for input ready");
                stop_run();
            end
        end
        @(negedge clk);
        s_axis_tvalid = 1'b0;
        // No gap after tlast, so the stall count stays exact
        if (!last) begin
            repeat (rand_bits(2)) @(negedge clk);
        end
    endtask

    task automatic take_result(input int stall0, input int stall1);
        // Decoy input beat while the input is closed
        s_axis_tvalid    = 1'(rand_bits(1));
        s_axis_beat.data = 8'(rand_bits(8));
        s_axis_beat.last = 1'(rand_bits(1));
        wait_out_valid("count beat");
        m_axis_tready = 1'b0;
        repeat (stall0) @(negedge clk);
        m_axis_tready = 1'b1;
        @(negedge clk);
        wait_out_valid("flag beat");
        m_axis_tready = 1'b0;
        repeat (stall1) @(negedge clk);
        m_axis_tready = 1'b1;
        @(negedge clk);
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'(rand_bits(1));
    endtask

    // Earlier low beats are random, the last one sets low
    task automatic run_packet(input int n_low, input logic [7:0] low, input logic [7:0] high,
                              input int stall0, input int stall1);
        int i;
        repeat (rand_bits(2)) @(negedge clk);
        for (i = 0; i < n_low; i++) begin
            send_beat((i == n_low - 1) ? low : 8'(rand_bits(8)), 1'b0);
        end
        send_beat(high, 1'b1);
        take_result(stall0, stall1);
    endtask

    initial begin
        int i;
        int stall0;
        lfsr          = 32'h4aa9_4c6d;
        rst_n         = 1'b0;
        s_axis_tvalid = 1'b0;
        s_axis_beat   = '0;
        m_axis_tready = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        // Idle with the output open, nothing may come out
        m_axis_tready = 1'b1;
        repeat (5) @(negedge clk);
        // Output always ready, count 0
        run_packet(1, 8'd0, 8'd0, 0, 0);
        run_packet(1, 8'd5, 8'd10, 0, 0);
        run_packet(1, 8'd200, 8'd3, 0, 0);
        // Window edges: count at low, at high, one past high
        run_packet(1, 8'd10, 8'd20, 10, 0);
        run_packet(1, 8'd10, 8'd20, 20, 3);
        run_packet(1, 8'd10, 8'd20, 21, 0);
        // Window through zero
        run_packet(1, 8'd250, 8'd5, 2, 0);
        run_packet(1, 8'd250, 8'd5, 100, 1);
        // 300 stalled cycles wrap to 44
        run_packet(1, 8'd40, 8'd50, 300, 0);
        // Lone tlast beat keeps low at 40
        run_packet(0, 8'd0, 8'd60, 30, 2);
        run_packet(2, 8'd100, 8'd110, 105, 0);
        for (i = 0; i < 40; i++) begin
            case (rand_bits(2))
                0: stall0 = 0;
                1: stall0 = rand_bits(3);
                2: stall0 = rand_bits(6);
                default: stall0 = rand_bits(9) % 301;
            endcase
            run_packet(rand_bits(2) % 3, 8'(rand_bits(8)), 8'(rand_bits(8)), stall0,
                       rand_bits(2));
        end
        repeat (3) @(negedge clk);
        if (flag_stalls == 0 || max_stall < 256) begin
            $display("Stimulus never stalled the flag beat or never wrapped the count");
            stop_run();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

/* build.f */
+incdir+hw
hw/wcmp_types_pkg.sv
hw/wcmp_stream_pkg.sv
hw/wcmp_threshold_capture.sv
hw/wcmp_stall_timer.sv
hw/wcmp_result_serializer.sv
hw/wcmp_ctrl.sv
hw/wcmp_top.sv
dv/tb_wcmp_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the stall-window monitor testbench with Verilator and runs it

set -u
cd "$(dirname "$0")" || exit 1

# Compile the packages, RTL and testbench into one executable
verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_wcmp_top \
    -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Run the model and keep its output for the verdict
output=$(./obj_dir/Vtb_wcmp_top 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The verdict line must stand alone in the output
if echo "$output" | grep -qx "Test passed"; then
    exit 0
else
    echo "Pass line not found in simulation output"
    exit 1
fi
